//--- rtl/cpu6_pkg.sv
package cpu6_pkg;

    localparam int data_w          = 8;
    localparam int log_addr_w      = 16;
    localparam int phys_addr_w     = 19;
    localparam int page_offset_w   = 11;
    localparam int page_base_w     = 3;
    localparam int page_index_w    = log_addr_w - page_offset_w + page_base_w;
    localparam int page_entry_w    = phys_addr_w - page_offset_w;
    localparam int reg_count       = 16;
    localparam int reg_addr_w      = $clog2(reg_count);
    localparam int reg_space_limit = 256;  // Low physical addresses loop back

    // Data-path bus source
    typedef enum logic [2:0] {
        dp_swap, dp_mar_hi, dp_mar_lo, dp_bus_read, dp_constant, dp_zero
    } dp_src_e;

    // R and S operand pair of the 2901
    typedef enum logic [1:0] {
        src_ab, src_da, src_dz, src_za
    } alu_src_e;

    typedef enum logic [2:0] {
        alu_add, alu_subr, alu_subs, alu_or, alu_and, alu_notrs, alu_exor, alu_exnor
    } alu_func_e;

    typedef enum logic {dest_none, dest_ram_f} alu_dest_e;

    typedef enum logic [1:0] {carry_zero, carry_one, carry_flag} carry_sel_e;

    typedef enum logic [1:0] {
        load_none, load_result, load_mar_from_war, load_page_base
    } load_sel_e;

    typedef enum logic [2:0] {
        addr_none, addr_war_hi, addr_war_lo, addr_war_inc, addr_mar_inc, addr_swap
    } addr_op_e;

    typedef enum logic [1:0] {
        store_none, store_page_write, store_bus_write, store_bus_read
    } store_op_e;

    typedef struct packed {
        logic carry;
        logic overflow;
        logic sign;
        logic zero;
    } alu_flags_t;

    typedef struct packed {
        dp_src_e               dp_src;
        alu_src_e              alu_src;
        alu_func_e             alu_func;
        alu_dest_e             alu_dest;
        carry_sel_e            carry_sel;
        load_sel_e             load_sel;
        addr_op_e              addr_op;
        store_op_e             store_op;
        logic [data_w-1:0]     constant;
        logic [reg_addr_w-1:0] reg_a;
        logic [reg_addr_w-1:0] reg_b;
    } microword_t;

    // Every control field at its none encoding
    localparam microword_t uop_none = '0;

    // Add and the two subtracts update carry and overflow
    function automatic logic is_arith(alu_func_e func);
        return (func == alu_add) || (func == alu_subr) || (func == alu_subs);
    endfunction

endpackage

//--- rtl/cpu6_alu.sv
`timescale 1ns/10ps

module cpu6_alu (
    input  logic                            clock,
    input  logic                            reset,
    input  logic [cpu6_pkg::reg_addr_w-1:0] reg_a,
    input  logic [cpu6_pkg::reg_addr_w-1:0] reg_b,
    input  cpu6_pkg::alu_src_e              src,
    input  cpu6_pkg::alu_func_e             func,
    input  cpu6_pkg::alu_dest_e             dest,
    input  logic                            carry_in,
    input  logic [cpu6_pkg::data_w-1:0]     d,
    output logic [cpu6_pkg::data_w-1:0]     f,
    output cpu6_pkg::alu_flags_t            flags
);
    import cpu6_pkg::*;

    logic [data_w-1:0] regs [reg_count];
    logic [data_w-1:0] r_op;
    logic [data_w-1:0] s_op;
    logic [data_w-1:0] add_x;
    logic [data_w-1:0] add_y;
    logic [data_w:0]   sum;

    always_comb begin
        r_op = regs[reg_a];  // ab
        s_op = regs[reg_b];
        case (src)
            src_da: begin
                r_op = d;
                s_op = regs[reg_a];
            end
            src_dz: begin
                r_op = d;
                s_op = '0;
            end
            src_za: begin
                r_op = '0;
                s_op = regs[reg_a];
            end
            default: ;
        endcase
    end

    // Subtracts invert one operand into the adder
    always_comb begin
        add_x = r_op;
        add_y = s_op;
        case (func)
            alu_subr: begin
                add_x = s_op;
                add_y = ~r_op;
            end
            alu_subs: add_y = ~s_op;
            default: ;
        endcase
    end

    assign sum = {1'b0, add_x} + {1'b0, add_y} + {{data_w{1'b0}}, carry_in};

    always_comb begin
        case (func)
            alu_or:    f = r_op | s_op;
            alu_and:   f = r_op & s_op;
            alu_notrs: f = ~r_op & s_op;
            alu_exor:  f = r_op ^ s_op;
            alu_exnor: f = ~(r_op ^ s_op);
            default:   f = sum[data_w-1:0];
        endcase
    end

    always_comb begin
        flags.carry    = 1'b0;  // Logic functions leave both clear
        flags.overflow = 1'b0;
        if (is_arith(func)) begin
            flags.carry    = sum[data_w];
            flags.overflow = (add_x[data_w-1] == add_y[data_w-1]) &&
                             (sum[data_w-1] != add_x[data_w-1]);
        end
        flags.sign = f[data_w-1];
        flags.zero = (f == '0);
    end

    always_ff @(posedge clock) begin
        if (!reset && dest == dest_ram_f) begin  // No writes while held in reset
            regs[reg_b] <= f;
        end
    end

endmodule

//--- rtl/cpu6_datapath.sv
`timescale 1ns/10ps

module cpu6_datapath (
    input  logic                            clock,
    input  logic                            reset,
    input  cpu6_pkg::microword_t            uop,
    input  logic [cpu6_pkg::log_addr_w-1:0] mar,
    input  logic [cpu6_pkg::data_w-1:0]     read_byte,
    output logic [cpu6_pkg::data_w-1:0]     dp_bus,
    output logic [cpu6_pkg::data_w-1:0]     result
);
    import cpu6_pkg::*;

    logic [data_w-1:0] swap_reg;
    logic [data_w-1:0] alu_f;
    alu_flags_t        alu_flags;
    alu_flags_t        flag_reg;
    logic              alu_carry_in;

    always_comb begin
        case (uop.dp_src)
            dp_swap:     dp_bus = swap_reg;
            dp_mar_hi:   dp_bus = {~mar[15:12], mar[11:8]};  // Board inverts the top nibble
            dp_mar_lo:   dp_bus = mar[7:0];
            dp_bus_read: dp_bus = read_byte;
            dp_constant: dp_bus = uop.constant;
            default:     dp_bus = '0;
        endcase
    end

    // Carry-in mux
    always_comb begin
        case (uop.carry_sel)
            carry_one:  alu_carry_in = 1'b1;
            carry_flag: alu_carry_in = flag_reg.carry;
            default:    alu_carry_in = 1'b0;
        endcase
    end

    cpu6_alu u_alu (
        .clock    (clock),
        .reset    (reset),
        .reg_a    (uop.reg_a),
        .reg_b    (uop.reg_b),
        .src      (uop.alu_src),
        .func     (uop.alu_func),
        .dest     (uop.alu_dest),
        .carry_in (alu_carry_in),
        .d        (dp_bus),
        .f        (alu_f),
        .flags    (alu_flags)
    );

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            result   <= '0;
            swap_reg <= '0;
            flag_reg <= '0;
        end else begin
            if (uop.load_sel == load_result) begin
                result <= alu_f;
            end
            if (uop.addr_op == addr_swap) begin
                swap_reg <= {dp_bus[3:0], dp_bus[7:4]};  // Nibble exchange
            end
            // Flags follow arithmetic writes to the register file
            if (uop.alu_dest == dest_ram_f && is_arith(uop.alu_func)) begin
                flag_reg <= alu_flags;
            end
        end
    end

endmodule

//--- rtl/cpu6_mmu.sv
`timescale 1ns/10ps

module cpu6_mmu (
    input  logic                             clock,
    input  logic                             reset,
    input  cpu6_pkg::microword_t             uop,
    input  logic [cpu6_pkg::data_w-1:0]      result,
    output logic [cpu6_pkg::log_addr_w-1:0]  mar,
    output logic [cpu6_pkg::phys_addr_w-1:0] phys_addr
);
    import cpu6_pkg::*;

    logic [log_addr_w-1:0]   war;
    logic [page_base_w-1:0]  page_base;
    logic [page_entry_w-1:0] page_table [2**page_index_w];
    logic [page_index_w-1:0] page_index;
    logic                    war_from_mar;
    logic [data_w-1:0]       war_hi_src;
    logic [data_w-1:0]       war_lo_src;

    // WAR byte loads take MAR when MAR is loaded from WAR in the same word
    assign war_from_mar = (uop.load_sel == load_mar_from_war);
    assign war_hi_src   = war_from_mar ? mar[15:8] : result;
    assign war_lo_src   = war_from_mar ? mar[7:0] : result;

    // Top five MAR bits over the base select the entry
    assign page_index = {mar[log_addr_w-1:page_offset_w], page_base};
    assign phys_addr  = {page_table[page_index], mar[page_offset_w-1:0]};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            mar       <= '0;
            war       <= '0;
            page_base <= '0;
        end else begin
            case (uop.load_sel)
                load_mar_from_war: mar <= war;
                load_page_base:    page_base <= result[page_base_w-1:0];
                default: ;
            endcase

            case (uop.addr_op)
                addr_war_hi:  war[15:8] <= war_hi_src;
                addr_war_lo:  war[7:0] <= war_lo_src;
                addr_war_inc: war <= war + 1'b1;
                addr_mar_inc: mar <= mar + 1'b1;  // Overrides a copy from WAR
                default: ;
            endcase
        end
    end

    // Page table RAM
    always_ff @(posedge clock) begin
        if (uop.store_op == store_page_write) begin
            page_table[page_index] <= result;
        end
    end

endmodule

//--- rtl/cpu6_bus_port.sv
`timescale 1ns/10ps

module cpu6_bus_port (
    input  logic                             clock,
    input  logic                             reset,
    input  cpu6_pkg::store_op_e              store_op,
    input  logic [cpu6_pkg::data_w-1:0]      dp_bus,
    input  logic [cpu6_pkg::phys_addr_w-1:0] phys_addr,
    input  logic [cpu6_pkg::data_w-1:0]      data_in,
    output logic [cpu6_pkg::data_w-1:0]      read_byte,
    output logic                             write_en,
    output logic [cpu6_pkg::phys_addr_w-1:0] address,
    output logic [cpu6_pkg::data_w-1:0]      data_out
);
    import cpu6_pkg::*;

    logic              write_pending;
    logic              reg_space;
    logic [data_w-1:0] read_src;

    // Register space reads see the write register
    assign reg_space = (phys_addr < phys_addr_w'(reg_space_limit));
    assign read_src  = reg_space ? data_out : data_in;
    assign address   = phys_addr;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            data_out      <= '0;
            write_pending <= 1'b0;
            write_en      <= 1'b0;
            read_byte     <= '0;
        end else begin
            write_pending <= (store_op == store_bus_write);
            write_en      <= write_pending;  // Strobe one cycle after the data
            if (store_op == store_bus_write) begin
                data_out <= dp_bus;
            end
            if (store_op == store_bus_read) begin
                read_byte <= read_src;
            end
        end
    end

endmodule

//--- rtl/cpu6.sv
`timescale 1ns/10ps

module cpu6 (
    input  logic                             clock,
    input  logic                             reset,
    input  cpu6_pkg::microword_t             uop,
    input  logic [cpu6_pkg::data_w-1:0]      data_in,
    output logic                             write_en,
    output logic [cpu6_pkg::phys_addr_w-1:0] address,
    output logic [cpu6_pkg::data_w-1:0]      data_out
);
    import cpu6_pkg::*;

    microword_t             pipe_uop;
    logic [data_w-1:0]      dp_bus;
    logic [data_w-1:0]      result;
    logic [data_w-1:0]      read_byte;
    logic [log_addr_w-1:0]  mar;
    logic [phys_addr_w-1:0] phys_addr;

    // Microword pipeline stage
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pipe_uop <= uop_none;
        end else begin
            pipe_uop <= uop;
        end
    end

    cpu6_datapath u_datapath (
        .clock     (clock),
        .reset     (reset),
        .uop       (pipe_uop),
        .mar       (mar),
        .read_byte (read_byte),
        .dp_bus    (dp_bus),
        .result    (result)
    );

    cpu6_mmu u_mmu (
        .clock     (clock),
        .reset     (reset),
        .uop       (pipe_uop),
        .result    (result),
        .mar       (mar),
        .phys_addr (phys_addr)
    );

    cpu6_bus_port u_bus_port (
        .clock     (clock),
        .reset     (reset),
        .store_op  (pipe_uop.store_op),
        .dp_bus    (dp_bus),
        .phys_addr (phys_addr),
        .data_in   (data_in),
        .read_byte (read_byte),
        .write_en  (write_en),
        .address   (address),
        .data_out  (data_out)
    );

endmodule

//--- testbench/cpu6_clock_gen.sv
`timescale 1ns/10ps

module cpu6_clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        repeat (3) @(posedge clock);  // Reset held for three cycles
        reset <= 1'b0;
    end

    always #4 clock = ~clock;  // 8 ns period

endmodule

//--- testbench/tb_cpu6.sv
`timescale 1ns/10ps

module tb_cpu6;
    import cpu6_pkg::*;

    // Upper bound on microwords issued by all tests together
    localparam int word_budget  = 300;
    localparam int strobe_limit = 6;

    logic                   clock;
    logic                   reset;
    microword_t             uop;
    logic [data_w-1:0]      data_in;
    logic                   write_en;
    logic [phys_addr_w-1:0] address;
    logic [data_w-1:0]      data_out;
    int                     seed = 33;

    cpu6_clock_gen u_clock_gen (
        .clock (clock),
        .reset (reset)
    );

    cpu6 u_cpu6 (
        .clock    (clock),
        .reset    (reset),
        .uop      (uop),
        .data_in  (data_in),
        .write_en (write_en),
        .address  (address),
        .data_out (data_out)
    );

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check(string name, logic [31:0] got, logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, expected));
        end
    endtask

    function automatic logic [7:0] rand_byte();
        return 8'($random(seed));
    endfunction

    // Reference 2901 function with the carry in bit 8
    function automatic logic [8:0] alu_model(alu_func_e func, logic [7:0] r, logic [7:0] s,
                                             logic cin);
        case (func)
            alu_add:   return {1'b0, r} + {1'b0, s} + cin;
            alu_subr:  return {1'b0, s} + {1'b0, ~r} + cin;
            alu_subs:  return {1'b0, r} + {1'b0, ~s} + cin;
            alu_or:    return {1'b0, r | s};
            alu_and:   return {1'b0, r & s};
            alu_notrs: return {1'b0, ~r & s};
            alu_exor:  return {1'b0, r ^ s};
            default:   return {1'b0, ~(r ^ s)};
        endcase
    endfunction

    task automatic send(microword_t w);
        @(posedge clock);
        uop <= w;
    endtask

    // Last word's register effects are visible afterwards
    task automatic flush();
        send(uop_none);
        send(uop_none);
        @(negedge clock);
    endtask

    task automatic load_reg(logic [3:0] idx, logic [7:0] value);
        microword_t w;
        w = uop_none;
        w.dp_src   = dp_constant;
        w.alu_src  = src_dz;
        w.alu_dest = dest_ram_f;  // D plus zero into register B
        w.reg_b    = idx;
        w.constant = value;
        send(w);
    endtask

    task automatic set_result(logic [7:0] value);
        microword_t w;
        w = uop_none;
        w.dp_src   = dp_constant;
        w.alu_src  = src_dz;
        w.load_sel = load_result;
        w.constant = value;
        send(w);
    endtask

    task automatic set_page_base(logic [7:0] value);
        microword_t w;
        set_result(value);
        w = uop_none;
        w.load_sel = load_page_base;
        send(w);
    endtask

    // Counts edges from capture of the bus_write word to the strobe
    task automatic wait_strobe();
        int edges;
        edges = 0;
        send(uop_none);
        @(negedge clock);
        while (write_en !== 1'b1) begin
            if (edges == strobe_limit) begin
                abort_run("Write strobe did not appear after a bus write");
            end
            send(uop_none);
            @(negedge clock);
            edges++;
        end
        check("write_en edges", edges, 2);
        send(uop_none);
        @(negedge clock);
        check("write_en width", write_en, 1'b0);
    endtask

    // Result goes through WAR low and MAR low onto the bus
    task automatic write_result_out(logic [7:0] expected, string name);
        microword_t w;
        w = uop_none;
        w.addr_op = addr_war_lo;
        send(w);
        w = uop_none;
        w.load_sel = load_mar_from_war;
        send(w);
        w = uop_none;
        w.dp_src   = dp_mar_lo;
        w.store_op = store_bus_write;
        send(w);
        wait_strobe();
        check(name, data_out, expected);
    endtask

    task automatic build_mar(logic [7:0] hi, logic [7:0] lo);
        microword_t w;
        set_result(hi);
        w = uop_none;
        w.addr_op = addr_war_hi;
        send(w);
        set_result(lo);
        w.addr_op = addr_war_lo;
        send(w);
        w = uop_none;
        w.load_sel = load_mar_from_war;
        send(w);
    endtask

    task automatic write_page_entry(logic [7:0] entry);
        microword_t w;
        set_result(entry);
        w = uop_none;
        w.store_op = store_page_write;
        send(w);
        flush();
    endtask

    task automatic test_reset_state();
        flush();
        check("write_en", write_en, 1'b0);
        check("data_out", data_out, 8'h00);
    endtask

    task automatic test_alu_functions();
        microword_t w;
        alu_func_e  func;
        logic [7:0] x;
        logic [7:0] y;
        logic [8:0] expected;
        int         i;
        x = rand_byte();
        y = rand_byte();
        load_reg(4'd1, x);
        load_reg(4'd2, y);
        for (i = 0; i < 8; i++) begin
            func = alu_func_e'(i);
            w = uop_none;
            w.alu_src  = src_ab;
            w.alu_func = func;
            w.reg_a    = 4'd1;
            w.reg_b    = 4'd2;
            w.load_sel = load_result;
            send(w);
            expected = alu_model(func, x, y, 1'b0);
            write_result_out(expected[7:0], $sformatf("data_out %s", func.name()));
        end
    endtask

    task automatic test_carry_chain();
        microword_t w;
        microword_t with_carry;
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] c;
        logic [8:0] ab_sum;
        logic [8:0] expected;
        a = rand_byte() | 8'h80;  // Both high bits set so a+b carries
        b = rand_byte() | 8'h80;
        c = rand_byte();
        ab_sum = alu_model(alu_add, a, b, 1'b0);
        load_reg(4'd3, a);
        load_reg(4'd4, b);
        load_reg(4'd5, c);  // Leaves flag carry clear
        with_carry = uop_none;
        with_carry.alu_src   = src_ab;
        with_carry.reg_a     = 4'd3;
        with_carry.reg_b     = 4'd5;
        with_carry.carry_sel = carry_flag;
        with_carry.load_sel  = load_result;
        send(with_carry);
        expected = alu_model(alu_add, a, c, 1'b0);
        write_result_out(expected[7:0], "data_out carry clear");
        w = uop_none;
        w.alu_src  = src_ab;
        w.reg_a    = 4'd3;
        w.reg_b    = 4'd4;
        w.alu_dest = dest_ram_f;
        send(w);
        send(with_carry);
        expected = alu_model(alu_add, a, c, ab_sum[8]);
        write_result_out(expected[7:0], "data_out carry set");
    endtask

    task automatic test_page_translation();
        microword_t w;
        logic [7:0] base;
        logic [7:0] hi;
        logic [7:0] lo;
        logic [7:0] entry;
        base  = rand_byte();
        hi    = rand_byte();
        lo    = rand_byte() & 8'hfe;  // Increment stays in the low byte
        entry = rand_byte() | 8'h01;  // Odd entry keeps the page external
        set_page_base(base);
        build_mar(hi, lo);
        write_page_entry(entry);
        check("address", address, {entry, hi[2:0], lo});
        // Another base selects another entry of the same MAR page
        set_page_base(base ^ 8'h01);
        write_page_entry(entry ^ 8'h02);
        check("address other base", address, {entry ^ 8'h02, hi[2:0], lo});
        set_page_base(base);
        flush();
        check("address base restored", address, {entry, hi[2:0], lo});
        w = uop_none;
        w.addr_op = addr_mar_inc;
        send(w);
        flush();
        check("address mar_inc", address, {entry, hi[2:0], lo + 8'd1});
    endtask

    task automatic test_read_swap();
        microword_t w;
        logic [7:0] value;
        value = rand_byte();
        check("address external", address >= reg_space_limit, 1'b1);
        send(uop_none);
        data_in <= value;
        w = uop_none;
        w.store_op = store_bus_read;
        send(w);
        w = uop_none;
        w.dp_src  = dp_bus_read;
        w.addr_op = addr_swap;
        send(w);
        w = uop_none;
        w.dp_src   = dp_swap;
        w.store_op = store_bus_write;
        send(w);
        wait_strobe();
        check("data_out swap", data_out, {value[3:0], value[7:4]});
    endtask

    task automatic test_loopback();
        microword_t w;
        logic [7:0] hi;
        logic [7:0] lo;
        logic [7:0] k;
        hi = rand_byte() & 8'hf8;  // Offset bits 10..8 cleared
        lo = rand_byte();
        k  = rand_byte();
        build_mar(hi, lo);
        write_page_entry(8'h00);
        check("address reg space", address, {11'h000, lo});
        w = uop_none;
        w.dp_src   = dp_constant;
        w.constant = k;
        w.store_op = store_bus_write;
        send(w);
        wait_strobe();
        check("data_out constant", data_out, k);
        send(uop_none);
        data_in <= ~k;  // Must not be seen
        w = uop_none;
        w.store_op = store_bus_read;
        send(w);
        w = uop_none;
        w.dp_src   = dp_bus_read;
        w.store_op = store_bus_write;
        send(w);
        wait_strobe();
        check("data_out loopback", data_out, k);
    endtask

    initial begin
        uop     = uop_none;
        data_in = '0;
        wait (reset == 1'b0);
        test_reset_state();
        test_alu_functions();
        test_carry_chain();
        test_page_translation();
        test_read_swap();
        test_loopback();
        $display("All tests passed");
        $finish;
    end

    // Watchdog
    initial begin
        #(word_budget * 8 + 200);
        abort_run("Watchdog expired before the tests finished");
    end

endmodule

//--- flist.f
rtl/cpu6_pkg.sv
rtl/cpu6_alu.sv
rtl/cpu6_datapath.sv
rtl/cpu6_mmu.sv
rtl/cpu6_bus_port.sv
rtl/cpu6.sv
testbench/cpu6_clock_gen.sv
testbench/tb_cpu6.sv

//--- Bender.yml
package:
  name: cpu6

sources:
  - files:
      - rtl/cpu6_pkg.sv
      - rtl/cpu6_alu.sv
      - rtl/cpu6_datapath.sv
      - rtl/cpu6_mmu.sv
      - rtl/cpu6_bus_port.sv
      - rtl/cpu6.sv
  - target: test
    files:
      - testbench/cpu6_clock_gen.sv
      - testbench/tb_cpu6.sv
